/* source/corr_consts.svh */
// Correlator constants.
// Input count, count widths and the command opcodes shared by the design.
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// number of detector lines.
`define NUM_INPUTS 4

// width of one pulse or coincidence count, a multiple of 4.
`define RESOLUTION 16

// width of the capture-length counter, a multiple of 4.
`define LEN_WIDTH 32

// one counter per unordered pair of inputs.
`define NUM_BASELINES ((`NUM_INPUTS * (`NUM_INPUTS - 1)) / 2)

// upper-nibble command opcodes.
`define OP_INVERT 4'h1
`define OP_EDGE 4'h2
`define OP_CLEAR 4'h3
`define OP_INTEGRATE 4'h4

`endif

/* source/corr_pkg.sv */
// Correlator package.
// Count, baseline and packet-phase types, plus the saturating increment.
package corr_pkg;

	`include "corr_consts.svh"

	typedef logic [`RESOLUTION-1:0] count_t;

	typedef count_t [`NUM_INPUTS-1:0] count_array_t;

	// pair order is (0,1), (0,2) .. (0,N-1), (1,2) and so on.
	typedef count_t [`NUM_BASELINES-1:0] baseline_array_t;

	typedef logic [`LEN_WIDTH-1:0] capture_len_t;

	typedef enum logic [2:0] {
		PKT_IDLE,
		PKT_HEADER,
		PKT_BASELINES,
		PKT_PULSES,
		PKT_LENGTH,
		PKT_END
	} pkt_state_t;

	// counts stick at all ones.
	function automatic count_t sat_inc(count_t value, logic inc);
		if (inc && value != '1)
			return value + count_t'(1);
		return value;
	endfunction

endpackage

/* source/sample_bus_if.sv */
// Sample bus.
// Conditioned samples and window control, from the conditioner to the counters.
`timescale 1ns/1ps
`include "corr_consts.svh"

interface sample_bus_if;

	logic [`NUM_INPUTS-1:0] samples; // conditioned pulses.
	logic capture; // window level, aligned with samples.
	logic clear; // first cycle of a window or a clear command.
	logic closing; // cycle after the last window cycle.

	modport src (
		output samples,
		output capture,
		output clear,
		output closing
	);

	modport dst (
		input samples,
		input capture,
		input clear,
		input closing
	);

endinterface

/* source/line_conditioner.sv */
// Line conditioner.
// Registers the detector lines, applies inversion and level or edge mode,
// and derives the window level, clear and closing pulses.
`timescale 1ns/1ps
`include "corr_consts.svh"

module line_conditioner (
	input logic intclk,
	input logic reset,
	input logic [`NUM_INPUTS-1:0] line_in,
	input logic strobe,
	input logic [`NUM_INPUTS-1:0] invert_mask,
	input logic edge_mode,
	input logic integrate,
	input logic clear_req,
	sample_bus_if.src bus
);

	logic [`NUM_INPUTS-1:0] line_q;
	logic [`NUM_INPUTS-1:0] line_prev;
	logic [`NUM_INPUTS-1:0] cond_now;
	logic [`NUM_INPUTS-1:0] cond_prev;
	logic window_q;

	assign cond_now = line_q ^ invert_mask;
	assign cond_prev = line_prev ^ invert_mask;

	// ##################################################
	// first stage, lines and previous values
	always_ff @(posedge intclk) begin
		line_q <= line_in;
		line_prev <= line_q;
		if (edge_mode)
			bus.samples <= cond_now & ~cond_prev; // rising edges only.
		else
			bus.samples <= cond_now;
	end

	// ##################################################
	// window control, in step with the samples
	always_ff @(posedge intclk) begin
		if (reset) begin
			window_q <= 1'b0;
			bus.capture <= 1'b0;
			bus.clear <= 1'b0;
			bus.closing <= 1'b0;
		end else begin
			window_q <= strobe | integrate;
			bus.capture <= window_q;
			// bus.capture still holds the previous window level here.
			bus.clear <= (window_q & ~bus.capture) | clear_req;
			bus.closing <= ~window_q & bus.capture;
		end
	end

endmodule

/* source/pulse_counter.sv */
// Pulse counter.
// Saturating per-input pulse counts with overflow flags, and the number
// of window cycles since the last clear.
`timescale 1ns/1ps
`include "corr_consts.svh"

module pulse_counter
	import corr_pkg::*;
(
	input logic intclk,
	input logic reset,
	sample_bus_if.dst bus,
	output count_array_t counts,
	output logic [`NUM_INPUTS-1:0] overflow,
	output capture_len_t capture_len
);

	always_ff @(posedge intclk) begin
		if (reset) begin
			counts <= '0;
			overflow <= '0;
		end else begin
			for (int i = 0; i < `NUM_INPUTS; i++) begin
				if (bus.clear) begin
					// the clear cycle can already carry the first sample.
					counts[i] <= count_t'(bus.capture & bus.samples[i]);
					overflow[i] <= 1'b0;
				end else if (bus.capture) begin
					counts[i] <= sat_inc(counts[i], bus.samples[i]);
					if (&sat_inc(counts[i], bus.samples[i]))
						overflow[i] <= 1'b1; // sticky until clear.
				end
			end
		end
	end

	// window length in cycles.
	always_ff @(posedge intclk) begin
		if (reset)
			capture_len <= '0;
		else if (bus.clear)
			capture_len <= capture_len_t'(bus.capture);
		else if (bus.capture)
			capture_len <= capture_len + capture_len_t'(1);
	end

endmodule

/* source/coincidence_correlator.sv */
// Coincidence correlator.
// Lag-zero correlation, one saturating counter per pair of inputs that
// advances when both samples are high inside the window.
`timescale 1ns/1ps
`include "corr_consts.svh"

module coincidence_correlator
	import corr_pkg::*;
(
	input logic intclk,
	input logic reset,
	sample_bus_if.dst bus,
	output wire baseline_array_t correlations
);

	// ##################################################
	// one counter per pair (i, j) with i < j
	generate
		for (genvar i = 0; i < `NUM_INPUTS - 1; i++) begin : g_first
			for (genvar j = i + 1; j < `NUM_INPUTS; j++) begin : g_second
				// position of the pair in the baseline order.
				localparam int IDX = (i * (2 * `NUM_INPUTS - i - 1)) / 2 + j - i - 1;

				count_t pair_count;
				logic both;

				assign both = bus.samples[i] & bus.samples[j];

				always_ff @(posedge intclk) begin
					if (reset)
						pair_count <= '0;
					else if (bus.clear)
						pair_count <= count_t'(bus.capture & both);
					else if (bus.capture)
						pair_count <= sat_inc(pair_count, both);
				end

				assign correlations[IDX] = pair_count;
			end
		end
	endgenerate

endmodule

/* source/cmd_parser.sv */
// Command parser.
// Decodes single command bytes into the inversion mask, edge mode,
// integrate flag and a one-cycle clear request.
`timescale 1ns/1ps
`include "corr_consts.svh"

module cmd_parser (
	input logic intclk,
	input logic reset,
	input logic [7:0] rx_data,
	input logic rx_strobe,
	output logic [`NUM_INPUTS-1:0] invert_mask,
	output logic edge_mode,
	output logic integrate,
	output logic clear_req
);

	logic [3:0] opcode;
	logic [3:0] arg;

	assign opcode = rx_data[7:4];
	assign arg = rx_data[3:0];

	always_ff @(posedge intclk) begin
		if (reset) begin
			invert_mask <= '0;
			edge_mode <= 1'b0;
			integrate <= 1'b0;
			clear_req <= 1'b0;
		end else begin
			clear_req <= 1'b0;
			if (rx_strobe) begin
				case (opcode)
					`OP_INVERT: invert_mask <= `NUM_INPUTS'(arg);
					`OP_EDGE: edge_mode <= arg[0];
					`OP_CLEAR: begin
						if (arg == 4'h0)
							clear_req <= 1'b1;
					end
					`OP_INTEGRATE: begin
						if (arg[3:1] == 3'b000)
							integrate <= arg[0]; // 0x40 stops, 0x41 starts.
					end
					default: ; // unknown bytes are dropped.
				endcase
			end
		end
	end

endmodule

/* source/packet_builder.sv */
// Packet builder.
// Snapshots the counts when a window closes and sends them as an ASCII
// hex packet, one byte at a time, paced by tx_next.
`timescale 1ns/1ps
`include "corr_consts.svh"

module packet_builder
	import corr_pkg::*;
(
	input logic intclk,
	input logic reset,
	input logic closing,
	input count_array_t counts,
	input baseline_array_t correlations,
	input capture_len_t capture_len,
	input logic tx_next,
	output logic [7:0] tx_data,
	output logic tx_busy
);

	localparam int NIB_W = $clog2(`LEN_WIDTH / 4) + 1;
	localparam int FIELD_W = $clog2(`NUM_BASELINES + `NUM_INPUTS);
	localparam logic [NIB_W-1:0] COUNT_TOP = NIB_W'(`RESOLUTION / 4 - 1);
	localparam logic [NIB_W-1:0] LEN_TOP = NIB_W'(`LEN_WIDTH / 4 - 1);
	localparam logic [NIB_W-1:0] HDR_TOP = NIB_W'(2); // 'C' then two digits.

	pkt_state_t state;
	logic [FIELD_W-1:0] field;
	logic [NIB_W-1:0] nib;

	count_array_t snap_counts;
	baseline_array_t snap_corr;
	capture_len_t snap_len;

	logic [`LEN_WIDTH-1:0] word;
	logic [3:0] nib_val;
	logic [7:0] hex_char;

	// ##################################################
	// current character
	always_comb begin
		case (state)
			PKT_HEADER: word = `LEN_WIDTH'(8'(`NUM_INPUTS));
			PKT_BASELINES: word = `LEN_WIDTH'(snap_corr[field]);
			PKT_PULSES: word = `LEN_WIDTH'(snap_counts[field]);
			PKT_LENGTH: word = snap_len;
			default: word = '0;
		endcase
	end

	assign nib_val = 4'(word >> {nib, 2'b00});
	assign hex_char = (nib_val < 4'd10) ? 8'h30 + 8'(nib_val) : 8'h37 + 8'(nib_val);

	always_comb begin
		case (state)
			PKT_IDLE: tx_data = 8'h00;
			PKT_HEADER: tx_data = (nib == HDR_TOP) ? 8'h43 : hex_char;
			PKT_END: tx_data = 8'h0A;
			default: tx_data = hex_char;
		endcase
	end

	assign tx_busy = (state != PKT_IDLE);

	// snapshot taken only when the previous packet is done.
	always_ff @(posedge intclk) begin
		if (closing && state == PKT_IDLE) begin
			snap_counts <= counts;
			snap_corr <= correlations;
			snap_len <= capture_len;
		end
	end

	// ##################################################
	// sequencing, nibbles go most significant first
	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= PKT_IDLE;
			field <= '0;
			nib <= '0;
		end else if (state == PKT_IDLE) begin
			if (closing) begin
				state <= PKT_HEADER;
				field <= '0;
				nib <= HDR_TOP;
			end
		end else if (tx_next) begin
			if (nib != '0) begin
				nib <= nib - NIB_W'(1);
			end else begin
				case (state)
					PKT_HEADER: begin
						state <= PKT_BASELINES;
						field <= '0;
						nib <= COUNT_TOP;
					end
					PKT_BASELINES: begin
						nib <= COUNT_TOP;
						if (field == FIELD_W'(`NUM_BASELINES - 1)) begin
							state <= PKT_PULSES;
							field <= '0;
						end else begin
							field <= field + FIELD_W'(1);
						end
					end
					PKT_PULSES: begin
						if (field == FIELD_W'(`NUM_INPUTS - 1)) begin
							state <= PKT_LENGTH;
							nib <= LEN_TOP;
						end else begin
							field <= field + FIELD_W'(1);
							nib <= COUNT_TOP;
						end
					end
					PKT_LENGTH: state <= PKT_END;
					default: state <= PKT_IDLE; // line feed accepted.
				endcase
			end
		end
	end

endmodule

/* source/correlator_top.sv */
// Pulse correlator top level.
// Conditions the detector lines, counts pulses and pair coincidences over
// an integration window and reports them as an ASCII hex packet.
`timescale 1ns/1ps
`include "corr_consts.svh"

module correlator_top
	import corr_pkg::*;
(
	input logic intclk,
	input logic reset,
	input logic [`NUM_INPUTS-1:0] line_in,
	input logic strobe,
	input logic [7:0] rx_data,
	input logic rx_strobe,
	output logic [7:0] tx_data,
	output logic tx_busy,
	input logic tx_next,
	output logic [`NUM_INPUTS-1:0] overflow,
	output logic integrating
);

	logic [`NUM_INPUTS-1:0] invert_mask;
	logic edge_mode;
	logic integrate;
	logic clear_req;

	count_array_t counts;
	baseline_array_t correlations;
	capture_len_t capture_len;

	sample_bus_if bus ();

	assign integrating = bus.capture;

	cmd_parser i_cmd_parser (
		.intclk(intclk),
		.reset(reset),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.invert_mask(invert_mask),
		.edge_mode(edge_mode),
		.integrate(integrate),
		.clear_req(clear_req)
	);

	line_conditioner i_line_conditioner (
		.intclk(intclk),
		.reset(reset),
		.line_in(line_in),
		.strobe(strobe),
		.invert_mask(invert_mask),
		.edge_mode(edge_mode),
		.integrate(integrate),
		.clear_req(clear_req),
		.bus(bus.src)
	);

	pulse_counter i_pulse_counter (
		.intclk(intclk),
		.reset(reset),
		.bus(bus.dst),
		.counts(counts),
		.overflow(overflow),
		.capture_len(capture_len)
	);

	coincidence_correlator i_coincidence_correlator (
		.intclk(intclk),
		.reset(reset),
		.bus(bus.dst),
		.correlations(correlations)
	);

	packet_builder i_packet_builder (
		.intclk(intclk),
		.reset(reset),
		.closing(bus.closing),
		.counts(counts),
		.correlations(correlations),
		.capture_len(capture_len),
		.tx_next(tx_next),
		.tx_data(tx_data),
		.tx_busy(tx_busy)
	);

endmodule

/* testbench/tb_model.svh */
// Correlator reference model.
// Conditioning, counting and packet formatting for one window, computed
// from the recorded raw line samples and the current settings.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// level or rising-edge conditioning of one sample.
function automatic logic [`NUM_INPUTS-1:0] condition_lines(
	input logic [`NUM_INPUTS-1:0] cur,
	input logic [`NUM_INPUTS-1:0] prev,
	input logic [`NUM_INPUTS-1:0] inv,
	input logic edge_on
);
	logic [`NUM_INPUTS-1:0] now_v;
	logic [`NUM_INPUTS-1:0] prev_v;
	now_v = cur ^ inv;
	prev_v = prev ^ inv;
	if (edge_on)
		return now_v & ~prev_v;
	return now_v;
endfunction

// a count stops at all ones.
function automatic logic [`RESOLUTION-1:0] clamp_count(input int n);
	if (n >= (1 << `RESOLUTION) - 1)
		return {`RESOLUTION{1'b1}};
	return n[`RESOLUTION-1:0];
endfunction

function automatic logic [7:0] hex_ascii(input logic [3:0] n);
	if (n < 4'd10)
		return 8'h30 + 8'(n);
	return 8'h41 + 8'(n) - 8'd10; // upper-case letters.
endfunction

task automatic push_hex(input logic [63:0] value, input int digits);
	for (int d = digits - 1; d >= 0; d--)
		exp_bytes.push_back(hex_ascii(value[d*4 +: 4]));
endtask

// ##################################################
// expected packet for the samples of the last window
task automatic build_expected_packet(input logic [`NUM_INPUTS-1:0] inv, input logic edge_on);
	int pulses [`NUM_INPUTS];
	int pairs [`NUM_BASELINES];
	logic [`NUM_INPUTS-1:0] s;
	int idx;
	for (int i = 0; i < `NUM_INPUTS; i++)
		pulses[i] = 0;
	for (int b = 0; b < `NUM_BASELINES; b++)
		pairs[b] = 0;
	foreach (rec_cur[k]) begin
		s = condition_lines(rec_cur[k], rec_prev[k], inv, edge_on);
		idx = 0;
		for (int i = 0; i < `NUM_INPUTS; i++) begin
			pulses[i] += s[i];
			for (int j = i + 1; j < `NUM_INPUTS; j++) begin
				pairs[idx] += s[i] & s[j]; // pair order (0,1), (0,2) and so on.
				idx++;
			end
		end
	end
	exp_bytes.delete();
	exp_bytes.push_back(8'h43);
	push_hex(`NUM_INPUTS, 2);
	for (int b = 0; b < `NUM_BASELINES; b++)
		push_hex(clamp_count(pairs[b]), `RESOLUTION / 4);
	for (int i = 0; i < `NUM_INPUTS; i++)
		push_hex(clamp_count(pulses[i]), `RESOLUTION / 4);
	push_hex(rec_cur.size(), `LEN_WIDTH / 4);
	exp_bytes.push_back(8'h0A);
endtask

`endif

/* testbench/tb_correlator_top.sv */
// Correlator testbench.
// Drives detector lines and command bytes, captures the ASCII packets
// and compares them with the reference model.
`timescale 1ns/1ps
`include "corr_consts.svh"

module tb_correlator_top;

	logic intclk = 1'b0;
	logic reset;
	logic [`NUM_INPUTS-1:0] line_in;
	logic strobe;
	logic [7:0] rx_data;
	logic rx_strobe;
	logic tx_next;
	logic [7:0] tx_data;
	logic tx_busy;
	logic [`NUM_INPUTS-1:0] overflow;
	logic integrating;

	// recorded window and model settings.
	logic [`NUM_INPUTS-1:0] rec_cur[$];
	logic [`NUM_INPUTS-1:0] rec_prev[$];
	logic [7:0] exp_bytes[$];
	logic [7:0] rx_bytes[$];
	logic [`NUM_INPUTS-1:0] model_inv;
	logic [`NUM_INPUTS-1:0] last_line;
	logic model_edge;
	logic model_integ;
	logic win_prev;

	int errors = 0;
	int test_start_errors = 0;
	int test_num = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	`include "tb_model.svh"

	correlator_top i_dut (
		.intclk(intclk),
		.reset(reset),
		.line_in(line_in),
		.strobe(strobe),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.tx_next(tx_next),
		.overflow(overflow),
		.integrating(integrating)
	);

	always #10 intclk = ~intclk;

	// ##################################################
	// window recorder that sees the inputs as the first stage does
	always @(posedge intclk) begin : record_lines
		logic win;
		if (reset) begin
			model_inv = '0;
			model_edge = 1'b0;
			model_integ = 1'b0;
			win_prev = 1'b0;
			rec_cur.delete();
			rec_prev.delete();
		end else begin
			win = strobe | model_integ;
			if (win && !win_prev) begin
				rec_cur.delete(); // a new window restarts the counts.
				rec_prev.delete();
			end
			if (win) begin
				rec_cur.push_back(line_in);
				rec_prev.push_back(last_line);
			end
			win_prev = win;
			if (rx_strobe) begin
				case (rx_data[7:4])
					`OP_INVERT: model_inv = rx_data[`NUM_INPUTS-1:0];
					`OP_EDGE: model_edge = rx_data[0];
					`OP_CLEAR: begin
						if (rx_data[3:0] == 4'h0) begin
							rec_cur.delete();
							rec_prev.delete();
						end
					end
					`OP_INTEGRATE: begin
						if (rx_data[3:1] == 3'b000)
							model_integ = rx_data[0];
					end
					default: ;
				endcase
			end
		end
		last_line = line_in;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (errors == test_start_errors) begin
			tests_passed++;
			$display("test %0d %s: passed", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", test_num, name,
				errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic send_command(input logic [7:0] cmd);
		@(posedge intclk);
		rx_data <= cmd;
		rx_strobe <= 1'b1;
		@(posedge intclk);
		rx_strobe <= 1'b0;
	endtask

	// opens a strobe window with random or quiet lines.
	task automatic strobe_window(input int cycles, input bit random_lines);
		@(posedge intclk);
		strobe <= 1'b1;
		for (int c = 0; c < cycles; c++) begin
			@(posedge intclk);
			if (random_lines)
				line_in <= `NUM_INPUTS'($urandom);
		end
		@(posedge intclk);
		strobe <= 1'b0;
		line_in <= '0;
	endtask

	// ##################################################
	// packet receiver with random gaps before each accept
	task automatic receive_packet(input int max_gap);
		logic [7:0] held;
		int gap;
		int waited;
		bit done;
		rx_bytes.delete();
		done = 1'b0;
		waited = 0;
		@(negedge intclk);
		while (!tx_busy && waited < 20) begin
			@(negedge intclk);
			waited++;
		end
		if (!tx_busy) begin
			errors++;
			$display("no packet started within 20 cycles after the window closed");
			return;
		end
		while (!done && rx_bytes.size() < 64) begin
			held = tx_data;
			gap = $urandom_range(max_gap, 0);
			for (int g = 0; g < gap; g++) begin
				@(negedge intclk);
				if (tx_data !== held) begin
					errors++;
					$display("CHECK FAILED tx_data while held: got 0x%h expected 0x%h",
						tx_data, held);
				end
				if (tx_busy !== 1'b1) begin
					errors++;
					$display("CHECK FAILED tx_busy during packet: got 0x%h expected 0x1",
						tx_busy);
				end
			end
			rx_bytes.push_back(held);
			@(posedge intclk);
			tx_next <= 1'b1;
			@(posedge intclk);
			tx_next <= 1'b0;
			@(negedge intclk);
			if (held == 8'h0A)
				done = 1'b1;
		end
		if (!done) begin
			errors++;
			$display("no line feed arrived within 64 bytes");
		end
		check_value("tx_busy after line feed", tx_busy, 0);
	endtask

	task automatic compare_packet();
		if (rx_bytes.size() != exp_bytes.size()) begin
			errors++;
			$display("packet has %0d bytes but the model expects %0d",
				rx_bytes.size(), exp_bytes.size());
		end
		for (int k = 0; k < rx_bytes.size() && k < exp_bytes.size(); k++) begin
			if (rx_bytes[k] !== exp_bytes[k]) begin
				errors++;
				$display("CHECK FAILED tx_data byte %0d: got 0x%h expected 0x%h",
					k, rx_bytes[k], exp_bytes[k]);
			end
		end
	endtask

	task automatic receive_and_compare(input int max_gap);
		receive_packet(max_gap);
		build_expected_packet(model_inv, model_edge);
		compare_packet();
	endtask

	initial begin : main
		int waited;
		void'($urandom(18));
		reset = 1'b1;
		line_in = '0;
		strobe = 1'b0;
		rx_data = 8'h00;
		rx_strobe = 1'b0;
		tx_next = 1'b0;
		repeat (16) @(posedge intclk);
		reset <= 1'b0;

		repeat (2) @(posedge intclk);
		@(negedge intclk);
		check_value("tx_busy", tx_busy, 0);
		check_value("integrating", integrating, 0);
		check_value("overflow", overflow, 0);
		check_value("tx_data", tx_data, 0);
		end_test("reset state");

		// ##################################################
		// integrate flag window in level mode
		send_command(8'h41);
		for (int c = 0; c < 200; c++) begin
			@(posedge intclk);
			line_in <= `NUM_INPUTS'($urandom);
		end
		@(negedge intclk);
		check_value("integrating", integrating, 1);
		send_command(8'h40);
		@(posedge intclk);
		line_in <= '0;
		receive_and_compare(2);
		end_test("level mode");

		send_command(8'h15);
		send_command(8'h21);
		strobe_window(150, 1'b1);
		receive_and_compare(2);
		send_command(8'h10);
		send_command(8'h20);
		end_test("inversion and edge mode");

		strobe_window(100, 1'b1);
		receive_and_compare(12); // long holds on every byte.
		end_test("back-pressure");

		// ##################################################
		// saturation followed by a clear and an empty window
		@(posedge intclk);
		line_in <= '1;
		strobe <= 1'b1;
		repeat ((1 << `RESOLUTION) + 40) @(posedge intclk);
		strobe <= 1'b0;
		line_in <= '0;
		receive_and_compare(1);
		check_value("overflow", overflow, {`NUM_INPUTS{1'b1}});
		send_command(8'h30);
		waited = 0;
		@(negedge intclk);
		while (overflow !== '0 && waited < 10) begin
			@(negedge intclk);
			waited++;
		end
		check_value("overflow after clear", overflow, 0);
		strobe_window(20, 1'b0);
		receive_and_compare(1);
		end_test("saturation and clear");

		strobe_window(60, 1'b1);
		receive_and_compare(3);
		strobe_window(80, 1'b1);
		receive_and_compare(3); // only the second window counts.
		end_test("window restart");

		$display("tests %0d, passed %0d, failed %0d, failed checks %0d",
			test_num, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
+incdir+testbench
source/corr_pkg.sv
source/sample_bus_if.sv
source/line_conditioner.sv
source/pulse_counter.sv
source/coincidence_correlator.sv
source/cmd_parser.sv
source/packet_builder.sv
source/correlator_top.sv
testbench/tb_correlator_top.sv
